//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

    ///////////////////////////////////////////////////////////////////////
    // widths and constants
    ///////////////////////////////////////////////////////////////////////

    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    localparam addr_t       INST_BYTES = 32'd4;
    localparam int unsigned NUM_REGS   = 32;
    localparam addr_t       RESET_PC   = 32'h0000_0000;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    ///////////////////////////////////////////////////////////////////////
    // control encodings
    ///////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_COPY2
    } alu_op_e;

    typedef enum logic [1:0] {
        BR_X,
        BR_EQ,
        BR_NE,
        BR_LT
    } br_op_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    // WB_PC writes the link value pc+4
    typedef enum logic {
        WB_ALU,
        WB_PC
    } wb_sel_e;

    ///////////////////////////////////////////////////////////////////////
    // pipeline records
    ///////////////////////////////////////////////////////////////////////

    typedef struct packed {
        alu_op_e   alu_op;
        br_op_e    br_op;
        logic      jmp;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      rf_wen;
        wb_sel_e   wb_sel;
        reg_addr_t wb_addr;
    } ctrl_t;

    typedef struct packed {
        addr_t pc;
        inst_t inst;
    } stage_info_t;

    // pending register write, fwdable when wdata is final
    typedef struct packed {
        logic      valid;
        logic      fwdable;
        reg_addr_t addr;
        xlen_t     wdata;
    } fw_ctrl_t;

    typedef struct packed {
        addr_t addr;
        inst_t inst;
    } fetch_t;

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } redirect_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  is_br;
        logic  is_jmp;
        logic  taken;
        addr_t target;
    } br_info_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        logic      rf_wen;
        reg_addr_t rd;
        xlen_t     wdata;
    } retire_t;

endpackage

`default_nettype wire

//--- hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  wire core_pkg::stage_info_t info_i,
    input  wire core_pkg::ctrl_t       ctrl_i,
    input  wire core_pkg::xlen_t       imm_i,
    input  wire core_pkg::xlen_t       op1_i,
    input  wire core_pkg::xlen_t       op2_i,
    input  wire core_pkg::xlen_t       rs2_i,
    output core_pkg::xlen_t            alu_out_o,
    output logic                       taken_o,
    output core_pkg::addr_t            target_o
);

    logic br_cond;

    always_comb begin
        case (ctrl_i.alu_op)
            core_pkg::ALU_ADD:   alu_out_o = op1_i + op2_i;
            core_pkg::ALU_SUB:   alu_out_o = op1_i - op2_i;
            core_pkg::ALU_AND:   alu_out_o = op1_i & op2_i;
            core_pkg::ALU_OR:    alu_out_o = op1_i | op2_i;
            core_pkg::ALU_XOR:   alu_out_o = op1_i ^ op2_i;
            core_pkg::ALU_SLT:   alu_out_o = {31'b0, $signed(op1_i) < $signed(op2_i)};
            core_pkg::ALU_COPY2: alu_out_o = op2_i;
            default:             alu_out_o = '0;
        endcase
    end

    // compare rs1 against rs2
    always_comb begin
        case (ctrl_i.br_op)
            core_pkg::BR_EQ: br_cond = (op1_i == rs2_i);
            core_pkg::BR_NE: br_cond = (op1_i != rs2_i);
            core_pkg::BR_LT: br_cond = ($signed(op1_i) < $signed(rs2_i));
            default:         br_cond = 1'b0;
        endcase
    end

    assign taken_o = ctrl_i.jmp | br_cond;

    // imm is the B immediate for branches and the J immediate for jal
    assign target_o = info_i.pc + imm_i;

endmodule

`default_nettype wire

//--- hw/inst_decode.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  wire core_pkg::inst_t inst_i,
    output core_pkg::ctrl_t      ctrl_o,
    output core_pkg::xlen_t      imm_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    core_pkg::reg_addr_t rd;
    core_pkg::reg_addr_t rs1;
    core_pkg::reg_addr_t rs2;
    core_pkg::xlen_t     imm_i;
    core_pkg::xlen_t     imm_u;
    core_pkg::xlen_t     imm_b;
    core_pkg::xlen_t     imm_j;
    logic                use_rs1;
    logic                use_rs2;
    logic                wr_rd;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign rs1    = inst_i[19:15];
    assign rs2    = inst_i[24:20];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'h000};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    always_comb begin
        ctrl_o.alu_op  = core_pkg::ALU_ADD;
        ctrl_o.br_op   = core_pkg::BR_X;
        ctrl_o.jmp     = 1'b0;
        ctrl_o.op1_sel = core_pkg::OP1_RS1;
        ctrl_o.op2_sel = core_pkg::OP2_RS2;
        ctrl_o.wb_sel  = core_pkg::WB_ALU;
        imm_o          = imm_i;
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        wr_rd          = 1'b0;
        case (opcode)
            core_pkg::OPC_LUI: begin
                ctrl_o.alu_op  = core_pkg::ALU_COPY2;
                ctrl_o.op1_sel = core_pkg::OP1_ZERO;
                ctrl_o.op2_sel = core_pkg::OP2_IMM;
                imm_o          = imm_u;
                wr_rd          = 1'b1;
            end
            core_pkg::OPC_OP_IMM: begin
                ctrl_o.op2_sel = core_pkg::OP2_IMM;
                use_rs1        = 1'b1;
                wr_rd          = 1'b1;
                case (funct3)
                    3'b000: ctrl_o.alu_op = core_pkg::ALU_ADD;
                    3'b100: ctrl_o.alu_op = core_pkg::ALU_XOR;
                    3'b110: ctrl_o.alu_op = core_pkg::ALU_OR;
                    3'b111: ctrl_o.alu_op = core_pkg::ALU_AND;
                    default: begin
                        use_rs1 = 1'b0;
                        wr_rd   = 1'b0;
                    end
                endcase
            end
            core_pkg::OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                wr_rd   = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: ctrl_o.alu_op = core_pkg::ALU_ADD;
                    10'b0100000_000: ctrl_o.alu_op = core_pkg::ALU_SUB;
                    10'b0000000_010: ctrl_o.alu_op = core_pkg::ALU_SLT;
                    10'b0000000_100: ctrl_o.alu_op = core_pkg::ALU_XOR;
                    10'b0000000_110: ctrl_o.alu_op = core_pkg::ALU_OR;
                    10'b0000000_111: ctrl_o.alu_op = core_pkg::ALU_AND;
                    default: begin
                        use_rs1 = 1'b0;
                        use_rs2 = 1'b0;
                        wr_rd   = 1'b0;
                    end
                endcase
            end
            core_pkg::OPC_BRANCH: begin
                ctrl_o.alu_op = core_pkg::ALU_SUB;
                imm_o         = imm_b;
                use_rs1       = 1'b1;
                use_rs2       = 1'b1;
                case (funct3)
                    3'b000: ctrl_o.br_op = core_pkg::BR_EQ;
                    3'b001: ctrl_o.br_op = core_pkg::BR_NE;
                    3'b100: ctrl_o.br_op = core_pkg::BR_LT;
                    default: begin
                        use_rs1 = 1'b0;
                        use_rs2 = 1'b0;
                    end
                endcase
            end
            core_pkg::OPC_JAL: begin
                ctrl_o.jmp     = 1'b1;
                ctrl_o.op1_sel = core_pkg::OP1_PC;
                ctrl_o.op2_sel = core_pkg::OP2_IMM;
                ctrl_o.wb_sel  = core_pkg::WB_PC;
                imm_o          = imm_j;
                wr_rd          = 1'b1;
            end
            default: ;
        endcase
        // unused sources read x0 so they never match a pending write
        ctrl_o.rs1     = use_rs1 ? rs1 : '0;
        ctrl_o.rs2     = use_rs2 ? rs2 : '0;
        ctrl_o.wb_addr = rd;
        ctrl_o.rf_wen  = wr_rd & (rd != '0);
    end

endmodule

`default_nettype wire

//--- hw/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        valid_i,
    input  wire core_pkg::stage_info_t info_i,
    input  wire core_pkg::ctrl_t       ctrl_i,
    input  wire core_pkg::xlen_t       imm_i,
    input  wire core_pkg::fw_ctrl_t    fw_exe_i,
    input  wire core_pkg::fw_ctrl_t    fw_wb_i,
    input  wire core_pkg::xlen_t       rf_rdata1_i,
    input  wire core_pkg::xlen_t       rf_rdata2_i,
    output core_pkg::reg_addr_t        rf_raddr1_o,
    output core_pkg::reg_addr_t        rf_raddr2_o,
    output core_pkg::xlen_t            op1_o,
    output core_pkg::xlen_t            op2_o,
    output core_pkg::xlen_t            rs2_o,
    output logic                       hazard_o
);

    core_pkg::xlen_t       rs1_fwd;
    core_pkg::xlen_t       rs2_fwd;
    core_pkg::xlen_t       rs1_val;
    core_pkg::xlen_t       rs2_val;
    logic                  rs1_hz;
    logic                  rs2_hz;
    logic                  use_hold;
    logic                  hold_valid_q;
    core_pkg::stage_info_t hold_info_q;
    core_pkg::xlen_t       hold_rs1_q;
    core_pkg::xlen_t       hold_rs2_q;

    // youngest matching record wins, returns {hazard, data}
    function automatic logic [32:0] forward(
        input core_pkg::reg_addr_t addr,
        input core_pkg::xlen_t     rf_data,
        input core_pkg::fw_ctrl_t  fw_exe,
        input core_pkg::fw_ctrl_t  fw_wb
    );
        logic [32:0] res;
        if (addr == '0) begin
            res = '0;
        end else if (fw_exe.valid && fw_exe.addr == addr) begin
            res = {!fw_exe.fwdable, fw_exe.wdata};
        end else if (fw_wb.valid && fw_wb.addr == addr) begin
            res = {!fw_wb.fwdable, fw_wb.wdata};
        end else begin
            res = {1'b0, rf_data};
        end
        return res;
    endfunction

    assign rf_raddr1_o = ctrl_i.rs1;
    assign rf_raddr2_o = ctrl_i.rs2;

    assign {rs1_hz, rs1_fwd} = forward(ctrl_i.rs1, rf_rdata1_i, fw_exe_i, fw_wb_i);
    assign {rs2_hz, rs2_fwd} = forward(ctrl_i.rs2, rf_rdata2_i, fw_exe_i, fw_wb_i);

    // same branch still sitting here after a stall
    assign use_hold = hold_valid_q & valid_i & (hold_info_q == info_i);

    assign rs1_val  = use_hold ? hold_rs1_q : rs1_fwd;
    assign rs2_val  = use_hold ? hold_rs2_q : rs2_fwd;
    assign hazard_o = valid_i & !use_hold & (rs1_hz | rs2_hz);
    assign rs2_o    = rs2_val;

    always_comb begin
        case (ctrl_i.op1_sel)
            core_pkg::OP1_RS1: op1_o = rs1_val;
            core_pkg::OP1_PC:  op1_o = info_i.pc;
            default:           op1_o = '0;
        endcase
    end

    assign op2_o = (ctrl_i.op2_sel == core_pkg::OP2_IMM) ? imm_i : rs2_val;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hold_valid_q <= 1'b0;
        end else begin
            hold_valid_q <= valid_i & !hazard_o & (ctrl_i.br_op != core_pkg::BR_X);
        end
    end

    always_ff @(posedge clk) begin
        hold_info_q <= info_i;
        hold_rs1_q  <= rs1_val;
        hold_rs2_q  <= rs2_val;
    end

endmodule

`default_nettype wire

//--- hw/pipeline_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_core (
    input  wire                      clk,
    input  wire                      rst_n_i,
    input  wire                      fetch_valid_i,
    input  wire core_pkg::fetch_t    fetch_i,
    output logic                     fetch_ready_o,
    output core_pkg::redirect_t      redirect_o,
    output core_pkg::br_info_t       brinfo_o,
    output core_pkg::retire_t        retire_o
);

    // id stage
    logic                  id_valid;
    core_pkg::stage_info_t id_info;
    core_pkg::ctrl_t       id_ctrl;
    core_pkg::xlen_t       id_imm;

    // ds stage
    logic                  ds_valid;
    core_pkg::stage_info_t ds_info;
    core_pkg::ctrl_t       ds_ctrl;
    core_pkg::xlen_t       ds_imm;
    core_pkg::fw_ctrl_t    ds_fw;
    logic                  ds_hazard;
    core_pkg::xlen_t       ds_op1;
    core_pkg::xlen_t       ds_op2;
    core_pkg::xlen_t       ds_rs2;

    // exe stage
    logic                  exe_valid;
    logic                  exe_is_new;
    logic                  exe_br_checked;
    core_pkg::stage_info_t exe_info;
    core_pkg::ctrl_t       exe_ctrl;
    core_pkg::xlen_t       exe_imm;
    core_pkg::xlen_t       exe_op1;
    core_pkg::xlen_t       exe_op2;
    core_pkg::xlen_t       exe_rs2;
    core_pkg::fw_ctrl_t    exe_fw_q;
    core_pkg::fw_ctrl_t    exe_fw;
    core_pkg::xlen_t       exe_alu_out;
    core_pkg::xlen_t       exe_wdata;
    logic                  exe_taken;
    core_pkg::addr_t       exe_target;
    core_pkg::addr_t       exe_next_pc;

    // wb and register file
    core_pkg::fw_ctrl_t    wb_fw;
    core_pkg::reg_addr_t   rf_raddr1;
    core_pkg::reg_addr_t   rf_raddr2;
    core_pkg::xlen_t       rf_rdata1;
    core_pkg::xlen_t       rf_rdata2;

    logic                  check_pending;
    logic                  branch_fail;
    logic                  exe_stall;
    logic                  ds_stall;
    logic                  id_stall;
    logic                  flush_front;

    ///////////////////////////////////////////////////////////////////////
    // prediction check and stall chain
    ///////////////////////////////////////////////////////////////////////

    assign exe_next_pc = exe_taken ? exe_target : exe_info.pc + core_pkg::INST_BYTES;

    // younger instruction must sit at the true next pc
    assign check_pending = exe_valid & (exe_is_new | !exe_br_checked);
    assign branch_fail   = check_pending &
                           (ds_valid ? (ds_info.pc != exe_next_pc)
                                     : id_valid & (id_info.pc != exe_next_pc));

    // wait in exe until something younger shows up
    assign exe_stall     = (check_pending & !ds_valid & !id_valid) | branch_fail;
    assign ds_stall      = ds_hazard | (ds_valid & exe_stall);
    assign id_stall      = id_valid & ds_stall;
    assign fetch_ready_o = !id_stall;
    assign flush_front   = branch_fail | redirect_o.valid;

    ///////////////////////////////////////////////////////////////////////
    // forwarding records
    ///////////////////////////////////////////////////////////////////////

    // link value is final already in ds
    assign ds_fw = '{valid: ds_valid & ds_ctrl.rf_wen,
                     fwdable: ds_ctrl.wb_sel == core_pkg::WB_PC,
                     addr: ds_ctrl.wb_addr,
                     wdata: ds_info.pc + core_pkg::INST_BYTES};

    assign exe_fw = '{valid: exe_valid & exe_fw_q.valid, fwdable: exe_fw_q.fwdable,
                      addr: exe_fw_q.addr, wdata: exe_fw_q.wdata};

    assign exe_wdata = exe_fw_q.fwdable ? exe_fw_q.wdata : exe_alu_out;

    ///////////////////////////////////////////////////////////////////////
    // stage registers
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_valid       <= 1'b0;
            ds_valid       <= 1'b0;
            exe_valid      <= 1'b0;
            exe_is_new     <= 1'b0;
            exe_br_checked <= 1'b0;
        end else begin
            if (flush_front) begin
                id_valid <= 1'b0;
            end else if (!id_stall) begin
                id_valid <= fetch_valid_i;
            end
            if (branch_fail) begin
                ds_valid <= 1'b0;
            end else if (!ds_stall) begin
                ds_valid <= id_valid;
            end
            if (exe_stall) begin
                exe_is_new <= 1'b0;
                if (branch_fail) begin
                    exe_br_checked <= 1'b1;
                end
            end else begin
                // bubble on a data hazard
                exe_valid      <= ds_valid & !ds_hazard;
                exe_is_new     <= 1'b1;
                exe_br_checked <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!id_stall) begin
            id_info <= '{pc: fetch_i.addr, inst: fetch_i.inst};
        end
        if (!ds_stall) begin
            ds_info <= id_info;
            ds_ctrl <= id_ctrl;
            ds_imm  <= id_imm;
        end
        if (!exe_stall) begin
            exe_info <= ds_info;
            exe_ctrl <= ds_ctrl;
            exe_imm  <= ds_imm;
            exe_op1  <= ds_op1;
            exe_op2  <= ds_op2;
            exe_rs2  <= ds_rs2;
            exe_fw_q <= ds_fw;
        end
    end

    // redirect one cycle after detection, branch info once per instruction
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            redirect_o <= '0;
            brinfo_o   <= '0;
        end else begin
            redirect_o <= '{valid: branch_fail, addr: exe_next_pc};
            brinfo_o   <= '{valid: exe_valid & exe_is_new &
                                   (exe_ctrl.br_op != core_pkg::BR_X | exe_ctrl.jmp),
                            pc: exe_info.pc,
                            is_br: exe_ctrl.br_op != core_pkg::BR_X,
                            is_jmp: exe_ctrl.jmp,
                            taken: exe_taken,
                            target: exe_target};
        end
    end

    inst_decode u_decode (
        .inst_i (id_info.inst),
        .ctrl_o (id_ctrl),
        .imm_o  (id_imm)
    );

    operand_select u_opsel (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (ds_valid),
        .info_i      (ds_info),
        .ctrl_i      (ds_ctrl),
        .imm_i       (ds_imm),
        .fw_exe_i    (exe_fw),
        .fw_wb_i     (wb_fw),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .rf_raddr1_o (rf_raddr1),
        .rf_raddr2_o (rf_raddr2),
        .op1_o       (ds_op1),
        .op2_o       (ds_op2),
        .rs2_o       (ds_rs2),
        .hazard_o    (ds_hazard)
    );

    execute_unit u_exe (
        .info_i    (exe_info),
        .ctrl_i    (exe_ctrl),
        .imm_i     (exe_imm),
        .op1_i     (exe_op1),
        .op2_i     (exe_op2),
        .rs2_i     (exe_rs2),
        .alu_out_o (exe_alu_out),
        .taken_o   (exe_taken),
        .target_o  (exe_target)
    );

    reg_file u_rf (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .valid_i  (exe_valid & !exe_stall),
        .info_i   (exe_info),
        .ctrl_i   (exe_ctrl),
        .wdata_i  (exe_wdata),
        .raddr1_i (rf_raddr1),
        .raddr2_i (rf_raddr2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .fw_o     (wb_fw),
        .retire_o (retire_o)
    );

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        valid_i,
    input  wire core_pkg::stage_info_t info_i,
    input  wire core_pkg::ctrl_t       ctrl_i,
    input  wire core_pkg::xlen_t       wdata_i,
    input  wire core_pkg::reg_addr_t   raddr1_i,
    input  wire core_pkg::reg_addr_t   raddr2_i,
    output core_pkg::xlen_t            rdata1_o,
    output core_pkg::xlen_t            rdata2_o,
    output core_pkg::fw_ctrl_t         fw_o,
    output core_pkg::retire_t          retire_o
);

    logic                wb_valid_q;
    core_pkg::addr_t     wb_pc_q;
    logic                wb_rf_wen_q;
    core_pkg::reg_addr_t wb_rd_q;
    core_pkg::xlen_t     wb_wdata_q;
    core_pkg::xlen_t     regs [core_pkg::NUM_REGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc_q     <= info_i.pc;
        wb_rf_wen_q <= ctrl_i.rf_wen;
        wb_rd_q     <= ctrl_i.wb_addr;
        wb_wdata_q  <= wdata_i;
        // x0 stays untouched
        if (wb_valid_q && wb_rf_wen_q && wb_rd_q != '0) begin
            regs[wb_rd_q] <= wb_wdata_q;
        end
    end

    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    assign fw_o = '{valid: wb_valid_q & wb_rf_wen_q, fwdable: 1'b1,
                    addr: wb_rd_q, wdata: wb_wdata_q};

    assign retire_o = '{valid: wb_valid_q, pc: wb_pc_q, rf_wen: wb_rf_wen_q,
                        rd: wb_rd_q, wdata: wb_wdata_q};

endmodule

`default_nettype wire

//--- list.f
hw/core_pkg.sv
hw/inst_decode.sv
hw/operand_select.sv
hw/execute_unit.sv
hw/reg_file.sv
hw/pipeline_core.sv
test/core_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module core_tb -o core_sim \
    && ./obj_dir/core_sim | tee /dev/stderr | grep -q "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- test/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

    localparam int TEST_WORDS = 512;
    localparam int IMEM_WORDS = 256;
    localparam int MAX_RECS   = 64;

    logic                clk;
    logic                rst_n_i;
    logic                fetch_valid_i;
    core_pkg::fetch_t    fetch_i;
    logic                fetch_ready_o;
    core_pkg::redirect_t redirect_o;
    core_pkg::br_info_t  brinfo_o;
    core_pkg::retire_t   retire_o;

    logic [31:0] tests [TEST_WORDS];
    logic [31:0] imem [IMEM_WORDS];

    // expected records from the data file
    logic [31:0] ret_pc [MAX_RECS];
    logic [31:0] ret_rd [MAX_RECS];
    logic [31:0] ret_data [MAX_RECS];
    logic [31:0] br_pc [MAX_RECS];
    logic [31:0] br_taken [MAX_RECS];
    logic [31:0] br_target [MAX_RECS];
    logic [31:0] redir_addr [MAX_RECS];
    int          n_ret;
    int          n_br;
    int          n_redir;
    int          ri;
    int          bi;
    int          di;

    logic [31:0] lfsr_state;

    pipeline_core DUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_i       (fetch_i),
        .fetch_ready_o (fetch_ready_o),
        .redirect_o    (redirect_o),
        .brinfo_o      (brinfo_o),
        .retire_o      (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ///////////////////////////////////////////////////////////////////////
    // failure reporting
    ///////////////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("mismatch at time %0t: %s expected %h got %h", $time, name, exp, got);
            stop_run();
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ///////////////////////////////////////////////////////////////////////

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    task automatic random_bit(output logic b);
        lfsr_state = {lfsr_state[30:0],
                      lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
        b = lfsr_state[0];
    endtask

    // opcode 0 is unsupported so unlisted words decode as nops
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return {a[31:7] ^ a[24:0], 7'h00};
    endfunction

    task automatic load_tests();
        int p;
        logic [31:0] tag;
        for (int i = 0; i < TEST_WORDS; i++) begin
            tests[i] = '0;
        end
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = fill_word(i * 4);
        end
        $readmemh("test/core_tests.txt", tests);
        n_ret   = 0;
        n_br    = 0;
        n_redir = 0;
        p       = 0;
        tag     = tests[0];
        while (tag != 32'h0 && p < TEST_WORDS - 4) begin
            case (tag)
                32'h50: imem[tests[p+1] >> 2] = tests[p+2];
                32'h52: begin
                    ret_pc[n_ret]   = tests[p+1];
                    ret_rd[n_ret]   = tests[p+2];
                    ret_data[n_ret] = tests[p+3];
                    n_ret++;
                end
                32'h42: begin
                    br_pc[n_br]     = tests[p+1];
                    br_taken[n_br]  = tests[p+2];
                    br_target[n_br] = tests[p+3];
                    n_br++;
                    // pc+4 fetch means every taken branch redirects
                    if (tests[p+2] != 0) begin
                        redir_addr[n_redir] = tests[p+3];
                        n_redir++;
                    end
                end
                default: report_error("unknown record tag in the data file");
            endcase
            p   = p + 4;
            tag = tests[p];
        end
        if (n_ret == 0) begin
            report_error("no expected retire records were loaded");
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // output checkers
    ///////////////////////////////////////////////////////////////////////

    task automatic check_outputs();
        logic [6:0] br_opcode;
        if (retire_o.valid && ri < n_ret) begin
            check_value("retire_o.pc", ret_pc[ri], retire_o.pc);
            if (ret_rd[ri] != 0) begin
                check_value("retire_o.rf_wen", 32'd1, {31'd0, retire_o.rf_wen});
                check_value("retire_o.rd", ret_rd[ri], {27'd0, retire_o.rd});
                check_value("retire_o.wdata", ret_data[ri], retire_o.wdata);
            end else begin
                check_value("retire_o.rf_wen", 32'd0, {31'd0, retire_o.rf_wen});
            end
            ri++;
        end
        if (brinfo_o.valid) begin
            assert (bi < n_br) else report_error("branch info record beyond the expected list");
            check_value("brinfo_o.pc", br_pc[bi], brinfo_o.pc);
            check_value("brinfo_o.taken", br_taken[bi], {31'd0, brinfo_o.taken});
            check_value("brinfo_o.target", br_target[bi], brinfo_o.target);
            // rv32i major opcodes of the branch and jal formats
            br_opcode = imem[br_pc[bi] >> 2][6:0];
            check_value("brinfo_o.is_br", {31'd0, br_opcode == 7'b1100011},
                        {31'd0, brinfo_o.is_br});
            check_value("brinfo_o.is_jmp", {31'd0, br_opcode == 7'b1101111},
                        {31'd0, brinfo_o.is_jmp});
            bi++;
        end
        if (redirect_o.valid) begin
            assert (di < n_redir) else report_error("redirect that no taken branch explains");
            check_value("redirect_o.addr", redir_addr[di], redirect_o.addr);
            di++;
        end
    endtask

    task automatic check_idle();
        check_value("fetch_ready_o", 32'd1, {31'd0, fetch_ready_o});
        check_value("retire_o.valid", 32'd0, {31'd0, retire_o.valid});
        check_value("redirect_o.valid", 32'd0, {31'd0, redirect_o.valid});
        check_value("brinfo_o.valid", 32'd0, {31'd0, brinfo_o.valid});
    endtask

    ///////////////////////////////////////////////////////////////////////
    // one pass over the program
    ///////////////////////////////////////////////////////////////////////

    task automatic run_program(input logic gaps);
        logic [31:0]         pc;
        logic                accepted;
        logic                hold;
        logic                b0;
        logic                b1;
        core_pkg::redirect_t redir;
        int                  cycles;
        int                  limit;
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_i       = '0;
        repeat (8) @(posedge clk);
        #0.5;
        rst_n_i = 1'b1;
        ri      = 0;
        bi      = 0;
        di      = 0;
        cycles  = 0;
        limit   = 20 * n_ret + 100;
        pc      = core_pkg::RESET_PC;
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        #0.5;
        fetch_valid_i = 1'b1;
        fetch_i       = '{addr: pc, inst: imem[pc >> 2]};
        while (!(ri == n_ret && bi == n_br && di == n_redir)) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                report_error("timeout, the expected records did not all arrive");
            end
            check_outputs();
            accepted = fetch_valid_i & fetch_ready_o;
            redir    = redirect_o;
            @(posedge clk);
            #0.5;
            if (redir.valid) begin
                pc = redir.addr;
            end else if (accepted) begin
                pc = pc + core_pkg::INST_BYTES;
            end
            // an offer that was not taken stays on the bus
            hold = fetch_valid_i & !accepted & !redir.valid;
            if (!hold) begin
                fetch_valid_i = 1'b1;
                if (gaps) begin
                    random_bit(b0);
                    random_bit(b1);
                    fetch_valid_i = !(b0 & b1);
                end
            end
            fetch_i = '{addr: pc, inst: imem[pc >> 2]};
        end
    endtask

    initial begin
        rst_n_i       = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_i       = '0;
        lfsr_state    = 32'h1d00;
        load_tests();
        run_program(1'b0);
        run_program(1'b1);
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/core_tests.txt
// records of four words: tag (50=P 52=R 42=B) then P: addr inst 0,
// R: pc rd data (rd 0 means no write), B: pc taken target
00000050 00000000 00500093 00000000
00000050 00000004 00108133 00000000
00000050 00000008 FFD00193 00000000
00000050 0000000C 40110233 00000000
00000050 00000010 0011A2B3 00000000
00000050 00000014 12345337 00000000
00000050 00000018 0F036393 00000000
00000050 0000001C 0FF3F413 00000000
00000050 00000020 00F44493 00000000
00000050 00000024 0074F533 00000000
00000050 00000028 005565B3 00000000
00000050 0000002C 0095C633 00000000
00000050 00000030 00708013 00000000
00000050 00000034 001006B3 00000000
00000050 00000038 00408663 00000000
00000050 0000003C 00100713 00000000
00000050 00000040 00200713 00000000
00000050 00000044 00D09463 00000000
00000050 00000048 00300713 00000000
00000050 0000004C 0011C663 00000000
00000050 00000050 00400713 00000000
00000050 00000054 00500713 00000000
00000050 00000058 010007EF 00000000
00000050 0000005C 00600713 00000000
00000050 00000060 00700713 00000000
00000050 00000064 00800713 00000000
00000050 00000068 00E78833 00000000
00000050 0000006C FE30CCE3 00000000
00000050 00000070 00081463 00000000
00000050 00000074 00900713 00000000
00000050 00000078 00180893 00000000
00000050 0000007C 01188463 00000000
00000050 00000080 00A00713 00000000
00000050 00000084 41088933 00000000
00000052 00000000 00000001 00000005
00000052 00000004 00000002 0000000A
00000052 00000008 00000003 FFFFFFFD
00000052 0000000C 00000004 00000005
00000052 00000010 00000005 00000001
00000052 00000014 00000006 12345000
00000052 00000018 00000007 123450F0
00000052 0000001C 00000008 000000F0
00000052 00000020 00000009 000000FF
00000052 00000024 0000000A 000000F0
00000052 00000028 0000000B 000000F1
00000052 0000002C 0000000C 0000000E
00000052 00000030 00000000 00000000
00000052 00000034 0000000D 00000005
00000052 00000038 00000000 00000000
00000052 00000044 00000000 00000000
00000052 00000048 0000000E 00000003
00000052 0000004C 00000000 00000000
00000052 00000058 0000000F 0000005C
00000052 00000068 00000010 0000005F
00000052 0000006C 00000000 00000000
00000052 00000070 00000000 00000000
00000052 00000078 00000011 00000060
00000052 0000007C 00000000 00000000
00000052 00000084 00000012 00000001
00000042 00000038 00000001 00000044
00000042 00000044 00000000 0000004C
00000042 0000004C 00000001 00000058
00000042 00000058 00000001 00000068
00000042 0000006C 00000000 00000064
00000042 00000070 00000001 00000078
00000042 0000007C 00000001 00000084
00000000 00000000 00000000 00000000
